// File: src.f
+incdir+design
design/dmaPkg.sv
design/dmaRegisterFile.sv
design/dmaPriority.sv
design/dmaTimingControl.sv
design/dmaController.sv
tests/dmaChecker.sv
tests/dmaTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dmaTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -qx "Finished with no errors" $(LOG); then \
		echo "simulation ended early"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/dmaTb.sv
`default_nettype none

`include "dma_settings.svh"

module dmaTb;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int ClockPeriod = 100;
	localparam int ResetCycles = 2;
	localparam logic [31:0] Seed = 32'h7f40_e3f2;
	localparam int ProgramOps = 80;
	localparam int FixedTransfers = 40;
	localparam int RotatingTransfers = 12;
	localparam int CycleTransfers = 24;
	// one transfer: request, SO, up to 5 cycles of hlda delay, S1 S2 S4, back in SI
	localparam int TransferCycles = 14;
	localparam int WaitLimit = 40;
	// cpu accesses of tests 1, 2, 4, 5 and 6, two cycles each
	localparam int AccessCount = 16 + (ProgramOps + 18) + 2 + 30 + 7;
	localparam int TransferCount = FixedTransfers + RotatingTransfers + CycleTransfers + 4;
	localparam int WatchdogCycles =
		2 * (ResetCycles + 2 * AccessCount + TransferCycles * TransferCount) + 100;
	localparam dmaPkg::cpuAccessT IdleAccess =
		'{csN: 1'b1, iorN: 1'b1, iowN: 1'b1, addr: 4'd0, data: 8'd0};

	logic busIf = 1'b0;
	logic rstN;
	dmaPkg::cpuAccessT cpuAccess;
	logic [`DMA_DATA_WIDTH-1:0] dbOut;
	logic [`DMA_CHANNELS-1:0] dreq;
	logic [`DMA_CHANNELS-1:0] dack;
	logic hrq;
	logic hlda;
	logic aen;
	logic adstb;
	logic [`DMA_ADDR_WIDTH-1:0] addrOut;
	dmaPkg::busStrobesT strobes;

	int checkerErrors;
	int checkCount;
	int tbErrors = 0;
	int errorsBefore = 0;

	always #(ClockPeriod / 2) busIf = ~busIf;

	dmaController dut_i
	(
		.busIf(busIf),
		.rstN(rstN),
		.cpuAccess(cpuAccess),
		.dbOut(dbOut),
		.dreq(dreq),
		.dack(dack),
		.hrq(hrq),
		.hlda(hlda),
		.aen(aen),
		.adstb(adstb),
		.addrOut(addrOut),
		.strobes(strobes)
	);

	dmaChecker checker_i
	(
		.busIf(busIf),
		.rstN(rstN),
		.cpuAccess(cpuAccess),
		.dbOut(dbOut),
		.dreq(dreq),
		.dack(dack),
		.hrq(hrq),
		.hlda(hlda),
		.aen(aen),
		.adstb(adstb),
		.addrOut(addrOut),
		.strobes(strobes),
		.errorCount(checkerErrors),
		.checkCount(checkCount)
	);

	// one cpu cycle, then the port idles for a cycle
	task automatic accessRegister(input logic write, input logic [3:0] addr,
		input logic [7:0] data);
		@(posedge busIf);
		cpuAccess <= '{csN: 1'b0, iorN: write, iowN: !write, addr: addr, data: data};
		@(posedge busIf);
		cpuAccess <= IdleAccess;
	endtask

	// raise dreq, follow one transfer to its end and release the request
	task automatic serviceRequest(input logic [3:0] pattern, input logic shuffle);
		int waited;
		waited = 0;
		@(posedge busIf);
		dreq <= pattern;
		@(negedge busIf);
		// adstb marks S1
		while (!adstb && waited < WaitLimit)
		begin
			@(posedge busIf);
			if (shuffle)
			begin
				dreq <= 4'($urandom_range(1, 15));
			end
			@(negedge busIf);
			waited++;
		end
		@(posedge busIf);
		dreq <= 4'd0;
		@(negedge busIf);
		while (hrq && waited < WaitLimit)
		begin
			@(negedge busIf);
			waited++;
		end
		if (waited >= WaitLimit)
		begin
			tbErrors++;
			$display("transfer for request %b did not finish within %0d cycles",
				pattern, WaitLimit);
		end
	endtask

	task automatic readChannelRegisters();
		for (int a = 0; a < 8; a++)
		begin
			accessRegister(1'b0, 4'(a), 8'd0);
			accessRegister(1'b0, 4'(a), 8'd0);
		end
	endtask

	task automatic reportTest(input int number, input string name);
		int newErrors;
		newErrors = checkerErrors + tbErrors - errorsBefore;
		errorsBefore = checkerErrors + tbErrors;
		$display("test %0d %s: %s, %0d errors", number, name,
			newErrors == 0 ? "passed" : "failed", newErrors);
	endtask

	// grants the bus a random 0 to 5 cycles after hrq rises
	initial
	begin
		int delay;
		hlda = 1'b0;
		forever
		begin
			@(negedge busIf);
			if (hrq && !hlda)
			begin
				delay = $urandom_range(0, 5);
				repeat (delay) @(posedge busIf);
				@(posedge busIf);
				hlda <= 1'b1;
			end
			else if (!hrq && hlda)
			begin
				@(posedge busIf);
				hlda <= 1'b0;
			end
		end
	end

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		logic [1:0] channel;
		logic [7:0] count;
		rstN = 1'b0;
		cpuAccess = IdleAccess;
		dreq = 4'd0;
		void'($urandom(Seed));
		repeat (ResetCycles) @(posedge busIf);
		rstN <= 1'b1;

		readChannelRegisters();
		reportTest(1, "reset values");

		// random bytes, pointer clears, reads and mode writes mixed
		for (int i = 0; i < ProgramOps; i++)
		begin
			case ($urandom_range(0, 9))
				0: accessRegister(1'b1, dmaPkg::ClearPointer, 8'd0);
				1: accessRegister(1'b0, 4'($urandom_range(0, 7)), 8'd0);
				2: accessRegister(1'b1, dmaPkg::ModeWrite, {4'($urandom_range(0, 15)),
					2'($urandom_range(0, 2)), 2'($urandom_range(0, 3))});
				default: accessRegister(1'b1, 4'($urandom_range(0, 7)),
					8'($urandom_range(0, 255)));
			endcase
		end
		accessRegister(1'b0, dmaPkg::CommandStatus, 8'd0);
		accessRegister(1'b1, dmaPkg::ClearPointer, 8'd0);
		readChannelRegisters();
		reportTest(2, "register programming");

		for (int i = 0; i < FixedTransfers; i++)
		begin
			serviceRequest(4'($urandom_range(1, 15)), 1'b1);
		end
		reportTest(3, "fixed priority");

		// rotating priority with every channel requesting
		accessRegister(1'b1, dmaPkg::CommandStatus, 8'h10);
		repeat (RotatingTransfers) serviceRequest(4'hf, 1'b0);
		accessRegister(1'b1, dmaPkg::CommandStatus, 8'h00);
		reportTest(4, "rotating priority");

		// fresh addresses and transfer types, then single channel transfers
		accessRegister(1'b1, dmaPkg::ClearPointer, 8'd0);
		for (int c = 0; c < 4; c++)
		begin
			accessRegister(1'b1, 4'(2 * c), 8'($urandom_range(0, 255)));
			accessRegister(1'b1, 4'(2 * c), 8'($urandom_range(0, 255)));
			accessRegister(1'b1, dmaPkg::ModeWrite, {4'd0, 2'($urandom_range(0, 2)), 2'(c)});
		end
		for (int i = 0; i < CycleTransfers; i++)
		begin
			serviceRequest(4'b0001 << $urandom_range(0, 3), 1'b0);
		end
		accessRegister(1'b1, dmaPkg::ClearPointer, 8'd0);
		readChannelRegisters();
		reportTest(5, "transfer cycle");

		// small count, terminal count after count plus one transfers
		channel = 2'($urandom_range(0, 3));
		count = 8'($urandom_range(0, 3));
		accessRegister(1'b1, dmaPkg::ClearPointer, 8'd0);
		accessRegister(1'b1, {1'b0, channel, 1'b1}, count);
		accessRegister(1'b1, {1'b0, channel, 1'b1}, 8'd0);
		accessRegister(1'b0, dmaPkg::CommandStatus, 8'd0);
		repeat (count) serviceRequest(4'b0001 << channel, 1'b0);
		accessRegister(1'b0, dmaPkg::CommandStatus, 8'd0);
		serviceRequest(4'b0001 << channel, 1'b0);
		accessRegister(1'b0, dmaPkg::CommandStatus, 8'd0);
		accessRegister(1'b0, dmaPkg::CommandStatus, 8'd0);
		reportTest(6, "terminal count");

		$display("checks %0d, errors %0d", checkCount, checkerErrors + tbErrors);
		if (checkerErrors + tbErrors == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/dmaChecker.sv
`default_nettype none

`include "dma_settings.svh"

module dmaChecker
(
	input logic busIf,
	input logic rstN,
	input dmaPkg::cpuAccessT cpuAccess,
	input logic [`DMA_DATA_WIDTH-1:0] dbOut,
	input logic [`DMA_CHANNELS-1:0] dreq,
	input logic [`DMA_CHANNELS-1:0] dack,
	input logic hrq,
	input logic hlda,
	input logic aen,
	input logic adstb,
	input logic [`DMA_ADDR_WIDTH-1:0] addrOut,
	input dmaPkg::busStrobesT strobes,
	output int errorCount,
	output int checkCount
);

	timeunit 1ns;
	timeprecision 1ns;

	int errors = 0;
	int checks = 0;

	// model of the controller, only what can be seen from outside
	logic [`DMA_ADDR_WIDTH-1:0] curAddr [`DMA_CHANNELS];
	logic [`DMA_ADDR_WIDTH-1:0] curCount [`DMA_CHANNELS];
	dmaPkg::transferTypeE modeType [`DMA_CHANNELS];
	logic [`DMA_DATA_WIDTH-1:0] command;
	logic [`DMA_CHANNELS-1:0] tcFlags;
	logic bytePointer;
	// highest ranked channel in rotating mode
	logic [1:0] topPtr;
	dmaPkg::dmaStateE state;
	logic [1:0] active;

	assign errorCount = errors;
	assign checkCount = checks;

	task automatic compareValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[FAIL] time %0t signal %s expected %h actual %h",
				$time, name, expected, actual);
		end
	endtask

	// first requesting channel, counting up from the one ranked highest
	function automatic int pickWinner(input logic [3:0] requests, input logic [1:0] highest);
		logic [1:0] channel;
		for (int step = 0; step < 4; step++)
		begin
			channel = highest + 2'(step);
			if (requests[channel])
			begin
				return int'(channel);
			end
		end
		return -1;
	endfunction

	// byte the cpu should see at a register address
	function automatic logic [7:0] expectedReadByte(input logic [3:0] addr);
		logic [15:0] value;
		if (addr < 4'd8)
		begin
			value = addr[0] ? curCount[addr[2:1]] : curAddr[addr[2:1]];
			return bytePointer ? value[15:8] : value[7:0];
		end
		else if (addr == dmaPkg::CommandStatus)
		begin
			return {4'b0000, tcFlags};
		end
		return 8'h00;
	endfunction

	// byte pointer picks which half of the register is replaced
	function automatic logic [15:0] writeByte(input logic [15:0] value, input logic [7:0] data);
		return bytePointer ? {data, value[7:0]} : {value[15:8], data};
	endfunction

	task automatic resetModel();
		for (int i = 0; i < `DMA_CHANNELS; i++)
		begin
			curAddr[i] = '0;
			curCount[i] = '0;
			modeType[i] = dmaPkg::TransferVerify;
		end
		command = '0;
		tcFlags = '0;
		bytePointer = 1'b0;
		topPtr = 2'd0;
		state = dmaPkg::SI;
		active = 2'd0;
	endtask

	task automatic checkOutputs();
		logic inTransfer;
		logic [3:0] expDack;
		logic [3:0] expStrobes;
		inTransfer = state inside {dmaPkg::S1, dmaPkg::S2, dmaPkg::S4};
		expDack = 4'd0;
		expStrobes = 4'b1111;
		if (state == dmaPkg::S2 || state == dmaPkg::S4)
		begin
			expDack[active] = 1'b1;
		end
		// strobe order is iorN iowN memrN memwN, read side in S2, write side in S4
		if (state == dmaPkg::S2 && modeType[active] == dmaPkg::TransferWrite)
			expStrobes = 4'b0111;
		else if (state == dmaPkg::S2 && modeType[active] == dmaPkg::TransferRead)
			expStrobes = 4'b1101;
		else if (state == dmaPkg::S4 && modeType[active] == dmaPkg::TransferWrite)
			expStrobes = 4'b1110;
		else if (state == dmaPkg::S4 && modeType[active] == dmaPkg::TransferRead)
			expStrobes = 4'b1011;
		compareValue("hrq", 16'(state != dmaPkg::SI), 16'(hrq));
		compareValue("aen", 16'(inTransfer), 16'(aen));
		compareValue("adstb", 16'(state == dmaPkg::S1), 16'(adstb));
		compareValue("dack", 16'(expDack), 16'(dack));
		compareValue("addrOut", inTransfer ? curAddr[active] : 16'd0, addrOut);
		compareValue("strobes", 16'(expStrobes), 16'(strobes));
		if (!cpuAccess.csN && !cpuAccess.iorN)
		begin
			compareValue("dbOut", 16'(expectedReadByte(cpuAccess.addr)), 16'(dbOut));
		end
	endtask

	// inputs seen now are the ones the next rising edge takes
	task automatic advanceModel();
		logic cpuWrite;
		logic cpuRead;
		logic channelAccess;
		logic [1:0] channel;
		int winner;
		cpuWrite = !cpuAccess.csN && !cpuAccess.iowN;
		cpuRead = !cpuAccess.csN && !cpuAccess.iorN;
		channelAccess = (cpuWrite || cpuRead) && cpuAccess.addr < 4'd8;
		channel = cpuAccess.addr[2:1];
		winner = pickWinner(dreq, command[4] ? topPtr : 2'd0);
		// status read clears first, a terminal count on the same edge survives
		if (cpuRead && cpuAccess.addr == dmaPkg::CommandStatus)
		begin
			tcFlags = '0;
		end
		case (state)
			dmaPkg::SI:
				if (!command[2] && dreq != 4'd0)
					state = dmaPkg::SO;
			dmaPkg::SO:
				if (hlda && winner >= 0)
				begin
					active = 2'(winner);
					state = dmaPkg::S1;
				end
				else if (hlda)
					state = dmaPkg::SI;
			dmaPkg::S1:
				state = dmaPkg::S2;
			dmaPkg::S2:
				state = dmaPkg::S4;
			default:
			begin
				// count passing zero is the terminal count
				if (curCount[active] == 16'd0)
					tcFlags[active] = 1'b1;
				curAddr[active] = curAddr[active] + 16'd1;
				curCount[active] = curCount[active] - 16'd1;
				if (command[4])
					topPtr = active + 2'd1;
				state = dmaPkg::SI;
			end
		endcase
		// cpu byte lands after the counter step and wins for its half
		if (cpuWrite && channelAccess && cpuAccess.addr[0])
			curCount[channel] = writeByte(curCount[channel], cpuAccess.data);
		else if (cpuWrite && channelAccess)
			curAddr[channel] = writeByte(curAddr[channel], cpuAccess.data);
		if (cpuWrite && cpuAccess.addr == dmaPkg::CommandStatus)
			command = cpuAccess.data;
		if (cpuWrite && cpuAccess.addr == dmaPkg::ModeWrite)
			modeType[cpuAccess.data[1:0]] = dmaPkg::transferTypeE'(cpuAccess.data[3:2]);
		if (cpuWrite && cpuAccess.addr == dmaPkg::ClearPointer)
			bytePointer = 1'b0;
		else if (channelAccess)
			bytePointer = !bytePointer;
	endtask

	// falling edge, all DUT outputs are settled
	always @(negedge busIf)
	begin
		if (!rstN)
		begin
			resetModel();
		end
		checkOutputs();
		if (rstN)
		begin
			advanceModel();
		end
	end

endmodule

`default_nettype wire

// File: design/dmaController.sv
`default_nettype none

`include "dma_settings.svh"

module dmaController
(
	input logic busIf,
	input logic rstN,
	input dmaPkg::cpuAccessT cpuAccess,
	output logic [`DMA_DATA_WIDTH-1:0] dbOut,
	input logic [`DMA_CHANNELS-1:0] dreq,
	output logic [`DMA_CHANNELS-1:0] dack,
	output logic hrq,
	input logic hlda,
	output logic aen,
	output logic adstb,
	output logic [`DMA_ADDR_WIDTH-1:0] addrOut,
	output dmaPkg::busStrobesT strobes
);

	// command bits
	logic enabled;
	logic rotating;

	// end of a transfer and the channel it served
	logic transferDone;
	logic [`DMA_CHANNEL_BITS-1:0] activeChannel;

	// active channel's view of the register file
	logic [`DMA_ADDR_WIDTH-1:0] currentAddress;
	dmaPkg::transferTypeE transferType;

	logic [`DMA_CHANNELS-1:0] grant;

	// cpu programming side
	dmaRegisterFile registerFile
	(
		.busIf(busIf),
		.rstN(rstN),
		.cpuAccess(cpuAccess),
		.dbOut(dbOut),
		.transferDone(transferDone),
		.activeChannel(activeChannel),
		.enabled(enabled),
		.rotating(rotating),
		.currentAddress(currentAddress),
		.transferType(transferType)
	);

	dmaPriority priorityLogic
	(
		.busIf(busIf),
		.rstN(rstN),
		.dreq(dreq),
		.rotating(rotating),
		.transferDone(transferDone),
		.activeChannel(activeChannel),
		.grant(grant)
	);

	// bus side, owns the hold handshake and strobes
	dmaTimingControl timingControl
	(
		.busIf(busIf),
		.rstN(rstN),
		.enabled(enabled),
		.dreq(dreq),
		.grant(grant),
		.hlda(hlda),
		.currentAddress(currentAddress),
		.transferType(transferType),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.addrOut(addrOut),
		.strobes(strobes),
		.transferDone(transferDone),
		.activeChannel(activeChannel)
	);

endmodule

`default_nettype wire

// File: design/dmaTimingControl.sv
`default_nettype none

`include "dma_settings.svh"

module dmaTimingControl
(
	input logic busIf,
	input logic rstN,
	input logic enabled,
	input logic [`DMA_CHANNELS-1:0] dreq,
	input logic [`DMA_CHANNELS-1:0] grant,
	input logic hlda,
	input logic [`DMA_ADDR_WIDTH-1:0] currentAddress,
	input dmaPkg::transferTypeE transferType,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic [`DMA_CHANNELS-1:0] dack,
	output logic [`DMA_ADDR_WIDTH-1:0] addrOut,
	output dmaPkg::busStrobesT strobes,
	output logic transferDone,
	output logic [`DMA_CHANNEL_BITS-1:0] activeChannel
);

	dmaPkg::dmaStateE state;
	dmaPkg::dmaStateE nextState;

	// channel number of the one-hot grant
	logic [`DMA_CHANNEL_BITS-1:0] grantIndex;

	always_comb
	begin
		grantIndex = '0;
		for (int i = 0; i < `DMA_CHANNELS; i++)
		begin
			if (grant[i])
			begin
				grantIndex = i[`DMA_CHANNEL_BITS-1:0];
			end
		end
	end

	// SI idle, SO waits for hlda, then S1 S2 S4 make one transfer
	always_comb
	begin
		nextState = state;
		case (state)
			dmaPkg::SI:
				if (enabled && |dreq)
				begin
					nextState = dmaPkg::SO;
				end
			dmaPkg::SO:
				// hlda may take any number of cycles
				if (hlda)
				begin
					// request went away meanwhile, give the bus back
					nextState = |grant ? dmaPkg::S1 : dmaPkg::SI;
				end
			dmaPkg::S1:
				nextState = dmaPkg::S2;
			dmaPkg::S2:
				nextState = dmaPkg::S4;
			default:
				nextState = dmaPkg::SI;
		endcase
	end

	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= dmaPkg::SI;
			activeChannel <= '0;
		end
		else
		begin
			state <= nextState;
			// latch the winner when the bus is handed over
			if (state == dmaPkg::SO && hlda && |grant)
			begin
				activeChannel <= grantIndex;
			end
		end
	end

	// hold request covers the whole service, dropped back in SI
	assign hrq = (state != dmaPkg::SI);
	assign aen = state inside {dmaPkg::S1, dmaPkg::S2, dmaPkg::S4};
	assign adstb = (state == dmaPkg::S1);
	assign transferDone = (state == dmaPkg::S4);
	assign addrOut = aen ? currentAddress : '0;

	// acknowledge and strobes
	always_comb
	begin
		dack = '0;
		strobes = '1;
		if (state == dmaPkg::S2 || state == dmaPkg::S4)
		begin
			dack[activeChannel] = 1'b1;
		end
		// S2 drives the read side, S4 the write side
		if (state == dmaPkg::S2)
		begin
			case (transferType)
				dmaPkg::TransferWrite:
					strobes.iorN = 1'b0;
				dmaPkg::TransferRead:
					strobes.memrN = 1'b0;
				default:
					strobes = '1;
			endcase
		end
		else if (state == dmaPkg::S4)
		begin
			case (transferType)
				dmaPkg::TransferWrite:
					strobes.memwN = 1'b0;
				dmaPkg::TransferRead:
					strobes.iowN = 1'b0;
				default:
					strobes = '1;
			endcase
		end
	end

	// address strobe is a single pulse and the acknowledge follows it
	adstbSinglePulse: assert property (@(posedge busIf) disable iff (!rstN)
		adstb |=> (!adstb && dack != '0));

	// io read and io write never overlap
	ioStrobesExclusive: assert property (@(posedge busIf) disable iff (!rstN)
		!(!strobes.iorN && !strobes.iowN));

	// only one channel acknowledged at a time
	dackOneHot: assert property (@(posedge busIf) disable iff (!rstN) $onehot0(dack));

endmodule

`default_nettype wire

// File: design/dmaPriority.sv
`default_nettype none

`include "dma_settings.svh"

module dmaPriority
(
	input logic busIf,
	input logic rstN,
	input logic [`DMA_CHANNELS-1:0] dreq,
	input logic rotating,
	input logic transferDone,
	input logic [`DMA_CHANNEL_BITS-1:0] activeChannel,
	output logic [`DMA_CHANNELS-1:0] grant
);

	// channel with the highest priority in rotating mode
	logic [`DMA_CHANNEL_BITS-1:0] topChannel;

	// where the search starts, channel 0 in fixed mode
	logic [`DMA_CHANNEL_BITS-1:0] firstChannel;

	// served channel drops to the bottom, the next one up takes the top
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			topChannel <= '0;
		end
		else if (transferDone && rotating)
		begin
			topChannel <= activeChannel + 1'b1;
		end
	end

	assign firstChannel = rotating ? topChannel : '0;

	// walk the ring from firstChannel, first request wins
	always_comb
	begin
		logic found;
		logic [`DMA_CHANNEL_BITS-1:0] index;
		found = 1'b0;
		grant = '0;
		for (int i = 0; i < `DMA_CHANNELS; i++)
		begin
			// index wraps around the channel ring
			index = firstChannel + i[`DMA_CHANNEL_BITS-1:0];
			if (!found && dreq[index])
			begin
				grant[index] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// at most one channel granted at a time
	grantOneHot: assert property (@(posedge busIf) disable iff (!rstN) $onehot0(grant));

endmodule

`default_nettype wire

// File: design/dmaRegisterFile.sv
`default_nettype none

`include "dma_settings.svh"

module dmaRegisterFile
(
	input logic busIf,
	input logic rstN,
	input dmaPkg::cpuAccessT cpuAccess,
	output logic [`DMA_DATA_WIDTH-1:0] dbOut,
	input logic transferDone,
	input logic [`DMA_CHANNEL_BITS-1:0] activeChannel,
	output logic enabled,
	output logic rotating,
	output logic [`DMA_ADDR_WIDTH-1:0] currentAddress,
	output dmaPkg::transferTypeE transferType
);

	// per channel address and count registers
	logic [`DMA_ADDR_WIDTH-1:0] baseAddressRegs [`DMA_CHANNELS];
	logic [`DMA_ADDR_WIDTH-1:0] curAddressRegs [`DMA_CHANNELS];
	logic [`DMA_ADDR_WIDTH-1:0] baseCountRegs [`DMA_CHANNELS];
	logic [`DMA_ADDR_WIDTH-1:0] curCountRegs [`DMA_CHANNELS];

	dmaPkg::commandRegT commandReg;
	dmaPkg::modeRegT modeRegs [`DMA_CHANNELS];
	logic [`DMA_CHANNELS-1:0] tcFlags;

	// selects the high byte of a 16 bit register when set
	logic bytePointer;

	// access decode
	dmaPkg::regAddrE regAddr;
	logic cpuWrite;
	logic cpuRead;
	logic isChannelReg;
	logic [`DMA_CHANNEL_BITS-1:0] regChannel;
	logic terminalCount;

	// low or high byte of a register, by the byte pointer
	function automatic logic [`DMA_DATA_WIDTH-1:0] pickByte
	(
		input logic [`DMA_ADDR_WIDTH-1:0] value,
		input logic high
	);
		return high ? value[`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] : value[`DMA_DATA_WIDTH-1:0];
	endfunction

	assign regAddr = dmaPkg::regAddrE'(cpuAccess.addr);
	assign cpuWrite = !cpuAccess.csN && !cpuAccess.iowN;
	assign cpuRead = !cpuAccess.csN && !cpuAccess.iorN;
	assign isChannelReg = (regAddr <= dmaPkg::Ch3Count);
	assign regChannel = cpuAccess.addr[`DMA_CHANNEL_BITS:1];

	// count of the finishing channel rolls past zero
	assign terminalCount = transferDone && (curCountRegs[activeChannel] == '0);

	// command bits seen by the rest of the controller
	assign enabled = !commandReg.controllerDisable;
	assign rotating = commandReg.rotating;

	// everything the timing block needs belongs to the active channel
	assign currentAddress = curAddressRegs[activeChannel];
	assign transferType = modeRegs[activeChannel].transferType;

	// readback, current registers and the status byte
	always_comb
	begin
		case (regAddr)
			dmaPkg::Ch0Address, dmaPkg::Ch1Address, dmaPkg::Ch2Address, dmaPkg::Ch3Address:
				dbOut = pickByte(curAddressRegs[regChannel], bytePointer);
			dmaPkg::Ch0Count, dmaPkg::Ch1Count, dmaPkg::Ch2Count, dmaPkg::Ch3Count:
				dbOut = pickByte(curCountRegs[regChannel], bytePointer);
			dmaPkg::CommandStatus:
				dbOut = {{(`DMA_DATA_WIDTH-`DMA_CHANNELS){1'b0}}, tcFlags};
			default:
				dbOut = '0;
		endcase
	end

	// channel registers
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `DMA_CHANNELS; i++)
			begin
				baseAddressRegs[i] <= '0;
				curAddressRegs[i] <= '0;
				baseCountRegs[i] <= '0;
				curCountRegs[i] <= '0;
			end
		end
		else
		begin
			// single transfer finished, step address up and count down
			if (transferDone)
			begin
				curAddressRegs[activeChannel] <= curAddressRegs[activeChannel] + 1'b1;
				curCountRegs[activeChannel] <= curCountRegs[activeChannel] - 1'b1;
			end
			// a cpu byte lands in base and current alike
			// on a clash it overrides only the byte it writes
			if (cpuWrite && isChannelReg && cpuAccess.addr[0])
			begin
				if (bytePointer)
				begin
					baseCountRegs[regChannel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= cpuAccess.data;
					curCountRegs[regChannel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= cpuAccess.data;
				end
				else
				begin
					baseCountRegs[regChannel][`DMA_DATA_WIDTH-1:0] <= cpuAccess.data;
					curCountRegs[regChannel][`DMA_DATA_WIDTH-1:0] <= cpuAccess.data;
				end
			end
			else if (cpuWrite && isChannelReg)
			begin
				if (bytePointer)
				begin
					baseAddressRegs[regChannel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= cpuAccess.data;
					curAddressRegs[regChannel][`DMA_ADDR_WIDTH-1:`DMA_DATA_WIDTH] <= cpuAccess.data;
				end
				else
				begin
					baseAddressRegs[regChannel][`DMA_DATA_WIDTH-1:0] <= cpuAccess.data;
					curAddressRegs[regChannel][`DMA_DATA_WIDTH-1:0] <= cpuAccess.data;
				end
			end
		end
	end

	// command, mode, status and the byte pointer
	always_ff @(posedge busIf or negedge rstN)
	begin
		if (!rstN)
		begin
			commandReg <= '0;
			tcFlags <= '0;
			bytePointer <= 1'b0;
			for (int i = 0; i < `DMA_CHANNELS; i++)
			begin
				modeRegs[i] <= '0;
			end
		end
		else
		begin
			if (cpuWrite && regAddr == dmaPkg::CommandStatus)
			begin
				commandReg <= dmaPkg::commandRegT'(cpuAccess.data);
			end
			// the mode byte names its own channel in bits 1..0
			if (cpuWrite && regAddr == dmaPkg::ModeWrite)
			begin
				modeRegs[cpuAccess.data[`DMA_CHANNEL_BITS-1:0]] <= dmaPkg::modeRegT'(cpuAccess.data);
			end
			// pointer flips on every channel access, read or write
			if (cpuWrite && regAddr == dmaPkg::ClearPointer)
			begin
				bytePointer <= 1'b0;
			end
			else if ((cpuWrite || cpuRead) && isChannelReg)
			begin
				bytePointer <= !bytePointer;
			end
			// status read clears, a new terminal count on the same edge still sticks
			if (cpuRead && regAddr == dmaPkg::CommandStatus)
			begin
				tcFlags <= '0;
			end
			if (terminalCount)
			begin
				tcFlags[activeChannel] <= 1'b1;
			end
		end
	end

	// the cpu port never reads and writes on one edge
	cpuAccessExclusive: assert property (@(posedge busIf) disable iff (!rstN)
		!(cpuWrite && cpuRead));

endmodule

`default_nettype wire

// File: design/dmaPkg.sv
`default_nettype none

`include "dma_settings.svh"

package dmaPkg;

	// timing states of the transfer FSM
	typedef enum logic [2:0] {
		SI = 3'd0,
		SO = 3'd1,
		S1 = 3'd2,
		S2 = 3'd3,
		S4 = 3'd4
	} dmaStateE;

	// transfer type field of a mode register
	// verify moves nothing and drives no strobes
	typedef enum logic [1:0] {
		TransferVerify = 2'd0,
		TransferWrite = 2'd1,
		TransferRead = 2'd2
	} transferTypeE;

	// register map of the programming port
	// bit 0 picks the count, bits 2..1 the channel
	typedef enum logic [`DMA_REG_ADDR_WIDTH-1:0] {
		Ch0Address = 4'd0,
		Ch0Count = 4'd1,
		Ch1Address = 4'd2,
		Ch1Count = 4'd3,
		Ch2Address = 4'd4,
		Ch2Count = 4'd5,
		Ch3Address = 4'd6,
		Ch3Count = 4'd7,
		CommandStatus = 4'd8,
		ModeWrite = 4'd11,
		ClearPointer = 4'd12
	} regAddrE;

	// one cpu access, all strobes active low
	typedef struct packed {
		logic csN;
		logic iorN;
		logic iowN;
		logic [`DMA_REG_ADDR_WIDTH-1:0] addr;
		logic [`DMA_DATA_WIDTH-1:0] data;
	} cpuAccessT;

	// bus cycle strobes, active low
	typedef struct packed {
		logic iorN;
		logic iowN;
		logic memrN;
		logic memwN;
	} busStrobesT;

	// command byte, only bits 4 and 2 have a meaning here
	typedef struct packed {
		logic [2:0] reservedHigh;
		logic rotating;
		logic reservedMid;
		logic controllerDisable;
		logic [1:0] reservedLow;
	} commandRegT;

	// mode byte, the upper nibble is kept as written
	typedef struct packed {
		logic [3:0] modeBits;
		transferTypeE transferType;
		logic [`DMA_CHANNEL_BITS-1:0] channel;
	} modeRegT;

endpackage

`default_nettype wire

// File: design/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// number of DMA channels
`define DMA_CHANNELS 4

// bits needed to name one channel
`define DMA_CHANNEL_BITS 2

// width of address and word count registers
`define DMA_ADDR_WIDTH 16

// width of the cpu data bus, one register byte
`define DMA_DATA_WIDTH 8

// register address on the programming port
`define DMA_REG_ADDR_WIDTH 4

`endif
